//--- controlUnit.f
src/ctrlPkg.sv
src/isaPkg.sv
src/instrDecoder.sv
src/stepSequencer.sv
src/ctrlEncoder.sv
src/controlUnit.sv
dv/controlUnit_chk.sv
dv/controlUnitTb.sv

//--- run.sh
#!/bin/sh
# Build and run the controlUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing -Wno-fatal --top-module controlUnitTb \
    -Mdir "$buildDir" -f controlUnit.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/VcontrolUnitTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "TEST RESULT: PASS" "$logFile"; then
    exit 0
fi
echo "Pass message not found in $logFile"
exit 1

//--- dv/controlUnitTb.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnitTb;
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int numTests   = 80;
    localparam int waitLimit  = 100;

    // Instruction kinds as the model sees them
    typedef enum {kAdd, kSub, kAnd, kSlt, kMult, kDiv, kAddi,
                  kLw, kSw, kBeq, kBne, kInvalid} kind_e;

    // Cycles and enable counts from acceptance to next ready
    typedef struct packed {
        int latency;
        int regWrite;
        int memRead;
        int memWrite;
        int hiLoWrite;
        int pcWrite;
        int epcWrite;
        int excTaken;
    } counts_t;

    logic         clk = 1'b0;
    logic         reset;
    instrFields_t instr;
    logic         instrValid;
    logic         instrReady;
    flags_t       flags;
    ctrlWord_t    ctrl;
    logic         busy;

    logic [15:0]  lfsr;
    int           errors;
    int           checks;
    logic         timedOut;

    controlUnit controlUnit_i (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .flags      (flags),
        .ctrl       (ctrl),
        .busy       (busy)
    );

    always #4 clk = ~clk;

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 16'hB400;
        return n;
    endfunction

    // One LFSR step per bit
    task automatic takeBits(input int count, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr = lfsrStep(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic checkValue(input string what, input int got, input int exp);
        checks++;
        assert (got == exp)
        else
        begin
            errors++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic reportTest(input int num, input string name, input int startErrors);
        if (errors == startErrors)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d errors", num, name, errors - startErrors);
    endtask

    // ISA table with the MIPS encodings
    function automatic kind_e classify(input instrFields_t f);
        kind_e k;
        k = kInvalid;
        case (f.opcode)
            opRType:
            begin
                case (f.funct)
                    functAdd:  k = kAdd;
                    functSub:  k = kSub;
                    functAnd:  k = kAnd;
                    functSlt:  k = kSlt;
                    functMult: k = kMult;
                    functDiv:  k = kDiv;
                    default:   k = kInvalid;
                endcase
            end
            opAddi:  k = kAddi;
            opLw:    k = kLw;
            opSw:    k = kSw;
            opBeq:   k = kBeq;
            opBne:   k = kBne;
            default: k = kInvalid;
        endcase
        return k;
    endfunction

    // Timing rules per class
    function automatic counts_t predict(input kind_e k, input logic ovf, input logic dz,
                                        input int zeroAt, input logic eq);
        counts_t c;
        logic    trapped;
        c = '0;
        trapped = 1'b0;
        // pcInc always writes PC
        c.pcWrite = 1;
        case (k)
            kAdd, kSub, kAddi:
            begin
                c.latency  = ovf ? 3 : 4;
                c.regWrite = ovf ? 0 : 1;
                trapped    = ovf;
            end
            kAnd, kSlt:
            begin
                c.latency  = 4;
                c.regWrite = 1;
            end
            kMult:
            begin
                c.latency   = 34;
                c.hiLoWrite = 32;
            end
            kDiv:
            begin
                c.latency   = dz ? zeroAt + 3 : 34;
                c.hiLoWrite = dz ? zeroAt + 1 : 32;
                trapped     = dz;
            end
            kLw:
            begin
                c.latency  = 7;
                c.memRead  = 2;
                c.regWrite = 2;
            end
            kSw:
            begin
                c.latency  = 4;
                c.memWrite = 1;
            end
            kBeq, kBne:
            begin
                c.latency = 4;
                // Taken on equal for beq, on not equal for bne
                if ((k == kBeq) == eq)
                    c.pcWrite = 2;
            end
            default:
            begin
                c.latency = 2;
                trapped   = 1'b1;
            end
        endcase
        // Exception tail is trap 5 plus jump 2
        if (trapped)
        begin
            c.latency  = c.latency + 7;
            c.epcWrite = 5;
            c.excTaken = 2;
            c.pcWrite  = c.pcWrite + 2;
        end
        return c;
    endfunction

    function automatic excCode_e expectedCode(input kind_e k, input logic ovf, input logic dz);
        if (k == kInvalid)
            return excInvalidOp;
        if (ovf && (k == kAdd || k == kSub || k == kAddi))
            return excOverflow;
        if (dz && k == kDiv)
            return excDivByZero;
        return excNone;
    endfunction

    // Stack pointer init right after reset release
    task automatic checkReset();
        int cycles;
        int spWrites;
        cycles = 0;
        spWrites = 0;
        @(negedge clk);
        while (!instrReady)
        begin
            if (ctrl.regWrite && ctrl.regDest == destStackPtr)
                spWrites++;
            checkValue("busy during init", int'(busy), 0);
            cycles++;
            if (cycles > waitLimit)
            begin
                timedOut = 1'b1;
                $display("Timeout: instrReady never rose after reset");
                return;
            end
            @(negedge clk);
        end
        checkValue("stack pointer writes", spWrites, 2);
        reportTest(0, "reset", 0);
    endtask

    task automatic runOne(input int num);
        logic [15:0]  r;
        instrFields_t f;
        flags_t       fl;
        kind_e        k;
        counts_t      exp;
        counts_t      got;
        excCode_e     code;
        aluOp_e       execOp;
        logic         ovf;
        logic         dz;
        logic         raised;
        int           gap;
        int           zeroAt;
        int           waited;
        int           startErrors;
        string        name;
        startErrors = errors;
        takeBits(12, r);
        f = r[11:0];
        takeBits(4, r);
        case (r[3:0])
            4'd0:  f = '{opcode: opRType, funct: functAdd};
            4'd1:  f = '{opcode: opRType, funct: functSub};
            4'd2:  f = '{opcode: opRType, funct: functAnd};
            4'd3:  f = '{opcode: opRType, funct: functSlt};
            4'd4:  f = '{opcode: opRType, funct: functMult};
            4'd5:  f = '{opcode: opRType, funct: functDiv};
            4'd6:  f.opcode = opAddi;
            4'd7:  f.opcode = opLw;
            4'd8:  f.opcode = opSw;
            4'd9:  f.opcode = opBeq;
            4'd10: f.opcode = opBne;
            // R-type with a random and mostly unused funct
            4'd11, 4'd12, 4'd13: f.opcode = opRType;
            default: ;
        endcase
        takeBits(2, r);
        gap = int'(r[1:0]);
        takeBits(2, r);
        ovf = (r[1:0] == 2'b11);
        fl = '0;
        takeBits(1, r);
        // Either overflow source traps
        fl.aluOverflow  = ovf && r[0];
        fl.multOverflow = ovf && !r[0];
        takeBits(1, r);
        dz = r[0];
        takeBits(5, r);
        zeroAt = int'(r[4:0]);
        takeBits(1, r);
        fl.equal = r[0];

        k = classify(f);
        exp = predict(k, ovf, dz, zeroAt, fl.equal);
        code = expectedCode(k, ovf, dz);
        name = $sformatf("%s (op %h funct %h)", k.name(), f.opcode, f.funct);

        // Idle gap with valid low
        repeat (gap) @(posedge clk);
        @(posedge clk);
        instr      <= f;
        instrValid <= 1'b1;
        flags      <= fl;
        // Hold valid until fetch shows ready
        waited = 0;
        @(negedge clk);
        while (!instrReady)
        begin
            waited++;
            if (waited > waitLimit)
            begin
                timedOut = 1'b1;
                $display("Timeout: instrReady never rose for %s", name);
                return;
            end
            @(negedge clk);
        end
        // Handshake completes on this edge
        @(posedge clk);
        instrValid <= 1'b0;

        got = '0;
        raised = 1'b0;
        execOp = aluLoad;
        while (1'b1)
        begin
            // Divide by zero shows up after zeroAt wait cycles
            if (dz && !raised && got.hiLoWrite == zeroAt)
            begin
                flags.divByZero <= 1'b1;
                raised = 1'b1;
            end
            @(negedge clk);
            if (instrReady)
                break;
            got.latency   += 1;
            got.regWrite  += int'(ctrl.regWrite);
            got.memRead   += int'(ctrl.memRead);
            got.memWrite  += int'(ctrl.memWrite);
            got.hiLoWrite += int'(ctrl.hiLoWrite);
            got.pcWrite   += int'(ctrl.pcWrite);
            got.epcWrite  += int'(ctrl.epcWrite);
            got.excTaken  += int'(ctrl.exceptionTaken);
            checkValue("busy", int'(busy), 1);
            // Third cycle is the execute state
            if (got.latency == 3)
                execOp = ctrl.aluOp;
            if (ctrl.epcWrite)
                checkValue("excCode", int'(ctrl.excCode), int'(code));
            if (got.latency > waitLimit)
            begin
                timedOut = 1'b1;
                $display("Timeout: %s never returned to ready", name);
                return;
            end
            @(posedge clk);
        end

        checkValue("latency", got.latency, exp.latency);
        checkValue("regWrite cycles", got.regWrite, exp.regWrite);
        checkValue("memRead cycles", got.memRead, exp.memRead);
        checkValue("memWrite cycles", got.memWrite, exp.memWrite);
        checkValue("hiLoWrite cycles", got.hiLoWrite, exp.hiLoWrite);
        checkValue("pcWrite cycles", got.pcWrite, exp.pcWrite);
        checkValue("epcWrite cycles", got.epcWrite, exp.epcWrite);
        checkValue("exceptionTaken cycles", got.excTaken, exp.excTaken);
        case (k)
            kAdd, kAddi: checkValue("aluOp", int'(execOp), int'(aluAdd));
            kSub:        checkValue("aluOp", int'(execOp), int'(aluSub));
            kAnd:        checkValue("aluOp", int'(execOp), int'(aluAnd));
            kSlt:        checkValue("aluOp", int'(execOp), int'(aluCmp));
            default: ;
        endcase
        reportTest(num, name, startErrors);
    endtask

    initial
    begin
        reset      = 1'b1;
        instr      = '0;
        instrValid = 1'b0;
        flags      = '0;
        lfsr       = 16'd63737;
        errors     = 0;
        checks     = 0;
        timedOut   = 1'b0;

        repeat (8) @(posedge clk);
        reset <= 1'b0;
        checkReset();
        for (int t = 1; t <= numTests && !timedOut; t++)
            runOne(t);

        $display("tests %0d, checks %0d, errors %0d", numTests + 1, checks, errors);
        if (errors == 0 && !timedOut)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/controlUnit_chk.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnit_chk (
    input logic               clk,
    input logic               reset,
    input logic               instrReady,
    input logic               busy,
    input ctrlPkg::ctrlWord_t ctrl
);
    import ctrlPkg::*;

    // Never busy while ready in fetch
    readyNotBusy: assert property (@(posedge clk) disable iff (reset)
        instrReady |-> !busy)
        else $error("instrReady high while busy");

    // One memory access per cycle
    memExclusive: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.memRead && ctrl.memWrite))
        else $error("memRead and memWrite high together");

    // EPC write carries a real cause
    epcHasCause: assert property (@(posedge clk) disable iff (reset)
        ctrl.epcWrite |-> (ctrl.excCode != excNone))
        else $error("epcWrite with no exception code");

endmodule

bind controlUnit controlUnit_chk controlUnit_chk_i (
    .clk        (clk),
    .reset      (reset),
    .instrReady (instrReady),
    .busy       (busy),
    .ctrl       (ctrl)
);

`default_nettype wire

//--- src/controlUnit.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
    input  logic                 clk,
    input  logic                 reset,
    input  isaPkg::instrFields_t instr,
    input  logic                 instrValid,
    output logic                 instrReady,
    input  ctrlPkg::flags_t      flags,
    output ctrlPkg::ctrlWord_t   ctrl,
    output logic                 busy
);
    import isaPkg::*;
    import ctrlPkg::*;

    instrFields_t heldInstr;
    decoded_t     decoded;
    state_e       state;
    excCode_e     excCode;

    // Decodes the held instruction, not the live input
    instrDecoder instrDecoder_i (
        .fields  (heldInstr),
        .decoded (decoded)
    );

    stepSequencer stepSequencer_i (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .flags      (flags),
        .decoded    (decoded),
        .heldInstr  (heldInstr),
        .state      (state),
        .excCode    (excCode),
        .busy       (busy)
    );

    ctrlEncoder ctrlEncoder_i (
        .state   (state),
        .decoded (decoded),
        .excCode (excCode),
        .equal   (flags.equal),
        .ctrl    (ctrl)
    );

endmodule

`default_nettype wire

//--- src/ctrlEncoder.sv
`timescale 1ns/1ns
`default_nettype none

module ctrlEncoder (
    input  ctrlPkg::state_e    state,
    input  isaPkg::decoded_t   decoded,
    input  ctrlPkg::excCode_e  excCode,
    input  logic               equal,
    output ctrlPkg::ctrlWord_t ctrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic takeBranch;

    // beq wants equal, bne wants not equal
    assign takeBranch = (decoded.instrClass == classBranchEq) ? equal : !equal;

    always_comb
    begin
        // All enables off, all muxes at their zero selection
        ctrl = '0;
        case (state)
            // Load the stack pointer with its reset value
            stInitSp:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.regDest  = destStackPtr;
                ctrl.memToReg = wbSpInit;
            end
            stFetch:
            begin
                ctrl.memRead = 1'b1;
            end
            // PC + 4
            stPcInc:
            begin
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = pcAluResult;
                ctrl.aluSrcB  = srcBFour;
                ctrl.aluOp    = aluAdd;
            end
            stDecode: ctrl.irWrite = 1'b1;
            stAluExec:
            begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = srcBRegB;
                ctrl.aluOp   = decoded.aluOp;
            end
            stWriteRd:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.regDest  = destRd;
                ctrl.memToReg = wbAluOut;
            end
            // Register plus immediate, also used for addresses
            stAddiExec, stAddrCalc:
            begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = srcBImm;
                ctrl.aluOp   = aluAdd;
            end
            stWriteRt:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.regDest  = destRt;
                ctrl.memToReg = wbAluOut;
            end
            stMulDivWait:
            begin
                ctrl.aluSrcA   = 1'b1;
                ctrl.hiLoWrite = 1'b1;
                ctrl.mulNotDiv = decoded.mulNotDiv;
            end
            stMemRead:
            begin
                ctrl.memRead = 1'b1;
                ctrl.iorD    = 1'b1;
            end
            stLoadWrite:
            begin
                ctrl.iorD     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.regDest  = destRt;
                ctrl.memToReg = wbMemData;
            end
            stMemWrite:
            begin
                ctrl.memWrite = 1'b1;
                ctrl.iorD     = 1'b1;
            end
            // Compare rs and rt, equal flag comes back next cycle
            stBranchCmp:
            begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = srcBRegB;
                ctrl.aluOp   = aluCmp;
            end
            stCondPc:
            begin
                ctrl.aluSrcA  = 1'b1;
                ctrl.aluSrcB  = srcBRegB;
                ctrl.aluOp    = aluCmp;
                ctrl.pcSource = pcBranchTarget;
                ctrl.pcWrite  = takeBranch;
            end
            // EPC gets PC - 4, the faulting instruction
            stTrap:
            begin
                ctrl.epcWrite = 1'b1;
                ctrl.excCode  = excCode;
                ctrl.aluSrcB  = srcBFour;
                ctrl.aluOp    = aluSub;
            end
            stExcJump:
            begin
                ctrl.pcWrite        = 1'b1;
                ctrl.pcSource       = pcExceptionVector;
                ctrl.exceptionTaken = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/stepSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module stepSequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  isaPkg::instrFields_t instr,
    input  logic                 instrValid,
    output logic                 instrReady,
    input  ctrlPkg::flags_t      flags,
    input  isaPkg::decoded_t     decoded,
    output isaPkg::instrFields_t heldInstr,
    output ctrlPkg::state_e      state,
    output ctrlPkg::excCode_e    excCode,
    output logic                 busy
);
    import isaPkg::*;
    import ctrlPkg::*;

    state_e                  stateNext;
    excCode_e                excCodeNext;
    logic [countWidth-1:0]   count;
    logic [countWidth-1:0]   countNext;
    logic                    accept;
    logic                    overflow;
    logic                    addSubOp;
    logic                    divZeroHit;

    // Only fetch can take an instruction
    assign instrReady = (state == stFetch);
    assign accept     = instrValid && instrReady;
    assign busy       = (state != stFetch) && (state != stInitSp);

    assign overflow   = flags.aluOverflow || flags.multOverflow;
    // and/slt cannot overflow, so only add and sub look at the flag
    assign addSubOp   = (decoded.aluOp == aluAdd) || (decoded.aluOp == aluSub);
    assign divZeroHit = flags.divByZero && !decoded.mulNotDiv;

    always_comb
    begin
        stateNext   = state;
        countNext   = count;
        excCodeNext = excCode;
        case (state)
            stInitSp:
            begin
                if (count == '0)
                    stateNext = stFetch;
                else
                    countNext = count - 1'b1;
            end
            stFetch:
            begin
                if (accept)
                    stateNext = stPcInc;
            end
            stPcInc: stateNext = stDecode;
            // Branch on instruction class
            stDecode:
            begin
                case (decoded.instrClass)
                    classAluR:   stateNext = stAluExec;
                    classAddImm: stateNext = stAddiExec;
                    classMulDiv:
                    begin
                        stateNext = stMulDivWait;
                        countNext = countWidth'(mulDivCycles - 1);
                    end
                    classLoad,
                    classStore:  stateNext = stAddrCalc;
                    classBranchEq,
                    classBranchNe: stateNext = stBranchCmp;
                    default:
                    begin
                        stateNext   = stTrap;
                        countNext   = countWidth'(trapCycles - 1);
                        excCodeNext = excInvalidOp;
                    end
                endcase
            end
            stAluExec, stAddiExec:
            begin
                if (overflow && addSubOp)
                begin
                    stateNext   = stTrap;
                    countNext   = countWidth'(trapCycles - 1);
                    excCodeNext = excOverflow;
                end
                else if (state == stAluExec)
                    stateNext = stWriteRd;
                else
                    stateNext = stWriteRt;
            end
            stWriteRd, stWriteRt: stateNext = stFetch;
            // Divide by zero aborts the wait at once
            stMulDivWait:
            begin
                if (divZeroHit)
                begin
                    stateNext   = stTrap;
                    countNext   = countWidth'(trapCycles - 1);
                    excCodeNext = excDivByZero;
                end
                else if (count == '0)
                    stateNext = stFetch;
                else
                    countNext = count - 1'b1;
            end
            stAddrCalc:
            begin
                if (decoded.instrClass == classLoad)
                begin
                    stateNext = stMemRead;
                    countNext = countWidth'(memWaitCycles - 1);
                end
                else
                    stateNext = stMemWrite;
            end
            stMemRead:
            begin
                if (count == '0)
                begin
                    stateNext = stLoadWrite;
                    countNext = countWidth'(memWaitCycles - 1);
                end
                else
                    countNext = count - 1'b1;
            end
            stLoadWrite, stExcJump:
            begin
                if (count == '0)
                    stateNext = stFetch;
                else
                    countNext = count - 1'b1;
            end
            stMemWrite:  stateNext = stFetch;
            stBranchCmp: stateNext = stCondPc;
            stCondPc:    stateNext = stFetch;
            stTrap:
            begin
                if (count == '0)
                begin
                    stateNext = stExcJump;
                    countNext = countWidth'(excJumpCycles - 1);
                end
                else
                    countNext = count - 1'b1;
            end
            default: stateNext = stFetch;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= stInitSp;
            count   <= countWidth'(initCycles - 1);
            excCode <= excNone;
        end
        else
        begin
            state   <= stateNext;
            count   <= countNext;
            excCode <= excCodeNext;
        end
    end

    // Instruction held for the whole sequence
    always_ff @(posedge clk)
    begin
        if (accept)
            heldInstr <= instr;
    end

endmodule

`default_nettype wire

//--- src/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
    input  isaPkg::instrFields_t fields,
    output isaPkg::decoded_t     decoded
);
    import isaPkg::*;
    import ctrlPkg::*;

    // Funct only matters for R-type
    decoded_t rTypeDecoded;

    always_comb
    begin
        rTypeDecoded.instrClass = classAluR;
        rTypeDecoded.aluOp      = aluLoad;
        rTypeDecoded.mulNotDiv  = 1'b0;
        case (fields.funct)
            functAdd: rTypeDecoded.aluOp = aluAdd;
            functSub: rTypeDecoded.aluOp = aluSub;
            functAnd: rTypeDecoded.aluOp = aluAnd;
            // slt is a compare in the ALU
            functSlt: rTypeDecoded.aluOp = aluCmp;
            functMult:
            begin
                rTypeDecoded.instrClass = classMulDiv;
                rTypeDecoded.mulNotDiv  = 1'b1;
            end
            functDiv: rTypeDecoded.instrClass = classMulDiv;
            default:  rTypeDecoded.instrClass = classInvalid;
        endcase
    end

    always_comb
    begin
        decoded.instrClass = classInvalid;
        decoded.aluOp      = aluLoad;
        decoded.mulNotDiv  = 1'b0;
        case (fields.opcode)
            opRType: decoded = rTypeDecoded;
            opAddi:
            begin
                decoded.instrClass = classAddImm;
                decoded.aluOp      = aluAdd;
            end
            // Address is base plus offset for both
            opLw:
            begin
                decoded.instrClass = classLoad;
                decoded.aluOp      = aluAdd;
            end
            opSw:
            begin
                decoded.instrClass = classStore;
                decoded.aluOp      = aluAdd;
            end
            opBeq:
            begin
                decoded.instrClass = classBranchEq;
                decoded.aluOp      = aluCmp;
            end
            opBne:
            begin
                decoded.instrClass = classBranchNe;
                decoded.aluOp      = aluCmp;
            end
            default: decoded.instrClass = classInvalid;
        endcase
    end

endmodule

`default_nettype wire

//--- src/isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int opcodeWidth = 6;
    localparam int functWidth  = 6;

    // Opcodes the controller understands
    typedef enum logic [opcodeWidth-1:0] {
        opRType = 6'h00,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcode_e;

    // R-type function codes
    typedef enum logic [functWidth-1:0] {
        functMult = 6'h18,
        functDiv  = 6'h1a,
        functAdd  = 6'h20,
        functSub  = 6'h22,
        functAnd  = 6'h24,
        functSlt  = 6'h2a
    } funct_e;

    // Raw fields as handed over, any bit pattern allowed
    typedef struct packed {
        logic [opcodeWidth-1:0] opcode;
        logic [functWidth-1:0]  funct;
    } instrFields_t;

    // Which path through the state sequence
    typedef enum logic [2:0] {
        classAluR,
        classMulDiv,
        classAddImm,
        classLoad,
        classStore,
        classBranchEq,
        classBranchNe,
        classInvalid
    } instrClass_e;

    typedef struct packed {
        instrClass_e     instrClass;
        ctrlPkg::aluOp_e aluOp;
        logic            mulNotDiv;
    } decoded_t;

endpackage

`default_nettype wire

//--- src/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    // ALU function select, same codes as the datapath ALU
    typedef enum logic [2:0] {
        aluLoad = 3'b000,
        aluAdd  = 3'b001,
        aluSub  = 3'b010,
        aluAnd  = 3'b011,
        aluCmp  = 3'b111
    } aluOp_e;

    // Next PC source mux
    typedef enum logic [1:0] {
        pcAluResult       = 2'd0,
        pcBranchTarget    = 2'd1,
        pcExceptionVector = 2'd2
    } pcSource_e;

    // Register file write address select
    typedef enum logic [1:0] {
        destRt       = 2'd0,
        destRd       = 2'd1,
        destStackPtr = 2'd2
    } regDest_e;

    // Register file write data select
    typedef enum logic [1:0] {
        wbAluOut  = 2'd0,
        wbMemData = 2'd1,
        wbSpInit  = 2'd2
    } memToReg_e;

    // ALU operand B select
    typedef enum logic [1:0] {
        srcBRegB = 2'd0,
        srcBFour = 2'd1,
        srcBImm  = 2'd2
    } aluSrcB_e;

    // Cause written alongside EPC
    typedef enum logic [1:0] {
        excNone      = 2'd0,
        excInvalidOp = 2'd1,
        excOverflow  = 2'd2,
        excDivByZero = 2'd3
    } excCode_e;

    // Full control word for the datapath, one per cycle
    typedef struct packed {
        logic      pcWrite;
        pcSource_e pcSource;
        logic      memRead;
        logic      memWrite;
        logic      iorD;
        logic      irWrite;
        logic      regWrite;
        regDest_e  regDest;
        memToReg_e memToReg;
        logic      aluSrcA;
        aluSrcB_e  aluSrcB;
        aluOp_e    aluOp;
        logic      hiLoWrite;
        logic      mulNotDiv;
        logic      epcWrite;
        excCode_e  excCode;
        logic      exceptionTaken;
    } ctrlWord_t;

    // Status coming back from the datapath
    typedef struct packed {
        logic aluOverflow;
        logic multOverflow;
        logic divByZero;
        logic equal;
    } flags_t;

    typedef enum logic [4:0] {
        stInitSp,
        stFetch,
        stPcInc,
        stDecode,
        stAluExec,
        stWriteRd,
        stAddiExec,
        stWriteRt,
        stMulDivWait,
        stAddrCalc,
        stMemRead,
        stLoadWrite,
        stMemWrite,
        stBranchCmp,
        stCondPc,
        stTrap,
        stExcJump
    } state_e;

    // Dwell times of the multi-cycle states
    localparam int initCycles    = 2;
    localparam int memWaitCycles = 2;
    localparam int mulDivCycles  = 32;
    localparam int trapCycles    = 5;
    localparam int excJumpCycles = 2;

    // Wide enough for the longest reload value
    localparam int countWidth = $clog2(mulDivCycles);

endpackage

`default_nettype wire
